// ==== design/msk_alu_ctl.sv ====
// ============================
// Masked ALU control
// Op decode, one-cycle sequencing and result select
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_alu_ctl (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_valid,
  input  msk_alu_pkg::msk_op_e    i_op,
  input  msk_alu_pkg::msk_share_t i_not_res,
  input  msk_alu_pkg::msk_share_t i_and_res,
  input  msk_alu_pkg::msk_share_t i_ior_res,
  input  msk_alu_pkg::msk_share_t i_xor_res,
  input  msk_alu_pkg::msk_share_t i_shf_res,
  input  msk_alu_pkg::msk_share_t i_gf_res,
  input  msk_alu_pkg::msk_share_t i_arith_res,   // Mask and remask
  input  msk_alu_pkg::msk_share_t i_addsub_res,
  output logic                    o_reg_en,
  output logic                    o_step,
  output logic                    o_ready,
  output logic                    o_left,
  output logic                    o_rotate,
  output logic                    o_bool,
  output logic                    o_remask,
  output logic                    o_sub,
  output msk_alu_pkg::msk_share_t o_rd
);

  localparam int SW = $bits(msk_alu_pkg::msk_share_t);

  logic sel_not;
  logic sel_and;
  logic sel_ior;
  logic sel_xor;
  logic sel_shf;
  logic sel_gf;
  logic sel_msk;
  logic sel_addsub;
  logic single_op;
  logic reg_op;
  logic busy_q;  // Registered op has its first cycle behind it

  always_comb begin
    {sel_not, sel_and, sel_ior, sel_xor} = 4'b0000;
    {sel_shf, sel_gf, sel_msk, sel_addsub} = 4'b0000;
    {o_left, o_rotate, o_bool, o_remask, o_sub} = 5'b00000;
    case (i_op)
      msk_alu_pkg::B_NOT:    sel_not = 1'b1;
      msk_alu_pkg::B_AND:    sel_and = 1'b1;
      msk_alu_pkg::B_IOR:    sel_ior = 1'b1;
      msk_alu_pkg::B_XOR:    sel_xor = 1'b1;
      msk_alu_pkg::B_SRLI:   sel_shf = 1'b1;
      msk_alu_pkg::B_SLLI:   {sel_shf, o_left} = 2'b11;
      msk_alu_pkg::B_RORI:   {sel_shf, o_rotate} = 2'b11;
      msk_alu_pkg::B_MASK:   {sel_msk, o_bool} = 2'b11;
      msk_alu_pkg::B_REMASK: {sel_msk, o_bool, o_remask} = 3'b111;
      msk_alu_pkg::A_MASK:   sel_msk = 1'b1;
      msk_alu_pkg::A_REMASK: {sel_msk, o_remask} = 2'b11;
      msk_alu_pkg::A_ADD:    sel_addsub = 1'b1;
      msk_alu_pkg::A_SUB:    {sel_addsub, o_sub} = 2'b11;
      msk_alu_pkg::F_MUL:    sel_gf = 1'b1;
      default:               sel_not = 1'b0;  // Unknown op never completes
    endcase
  end

  assign single_op = sel_not | sel_shf | sel_addsub | sel_gf;
  assign reg_op    = sel_and | sel_ior | sel_xor | sel_msk;

  assign o_reg_en = i_valid & reg_op & ~busy_q;  // Capture in the first cycle
  assign o_ready  = i_valid & (single_op | (reg_op & busy_q));
  assign o_step   = o_ready;  // Fresh randomness once per completed op

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= o_reg_en;
    end
  end

  // AND-OR gating keeps unselected shares off the result bus
  assign o_rd = ({SW{sel_not}}    & i_not_res)   |
                ({SW{sel_and}}    & i_and_res)   |
                ({SW{sel_ior}}    & i_ior_res)   |
                ({SW{sel_xor}}    & i_xor_res)   |
                ({SW{sel_shf}}    & i_shf_res)   |
                ({SW{sel_gf}}     & i_gf_res)    |
                ({SW{sel_msk}}    & i_arith_res) |
                ({SW{sel_addsub}} & i_addsub_res);

  // The requester keeps a registered op on the bus until it completes
  a_req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
    busy_q |-> i_valid && $stable(i_op))
    else $error("request dropped or changed while a registered op was in flight");

endmodule

`default_nettype wire

// ==== design/msk_alu_pkg.sv ====
// ============================
// Masked ALU shared types
// Word, share, op and request definitions
// ============================
`default_nettype none

package msk_alu_pkg;

  localparam int XLEN    = 32;  // Data word width
  localparam int SHAMT_W = 5;   // Shift amount width

  typedef logic [XLEN-1:0] msk_word_t;

  // Boolean value is s0 ^ s1, arithmetic value is s0 - s1
  typedef struct packed {
    msk_word_t s1;  // Upper word
    msk_word_t s0;
  } msk_share_t;

  // Share 0 of operand 2 holds data or a shift amount
  typedef union packed {
    msk_word_t word;
    struct packed {
      logic [XLEN-SHAMT_W-1:0] unused;
      logic [SHAMT_W-1:0]      shamt;
    } shift;
  } msk_rs2_u;

  typedef enum logic [3:0] {
    B_NOT,
    B_AND,
    B_IOR,
    B_XOR,
    B_SRLI,
    B_SLLI,
    B_RORI,
    B_MASK,
    B_REMASK,
    A_MASK,
    A_REMASK,
    A_ADD,
    A_SUB,
    F_MUL
  } msk_op_e;

  typedef struct packed {
    msk_op_e    op;
    msk_share_t rs1;
    msk_rs2_u   rs2_s0;
    msk_word_t  rs2_s1;
  } msk_req_t;

endpackage

`default_nettype wire

// ==== design/msk_alu_top.sv ====
// ============================
// Masked ALU top level
// Two-share TI execution unit with a valid/ready handshake
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_alu_top #(
  parameter msk_alu_pkg::msk_word_t PRNG_SEED = 32'h6789_ABCD
) (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_valid,
  input  msk_alu_pkg::msk_req_t   i_req,
  output logic                    o_ready,
  output msk_alu_pkg::msk_share_t o_rd
);

  msk_alu_pkg::msk_share_t rs2;  // Operand 2 as a share pair
  msk_alu_pkg::msk_word_t  rand_w;
  msk_alu_pkg::msk_word_t  shf_s0;
  msk_alu_pkg::msk_word_t  shf_s1;
  msk_alu_pkg::msk_share_t not_res;
  msk_alu_pkg::msk_share_t and_res;
  msk_alu_pkg::msk_share_t ior_res;
  msk_alu_pkg::msk_share_t xor_res;
  msk_alu_pkg::msk_share_t gf_res;
  msk_alu_pkg::msk_share_t mask_res;
  msk_alu_pkg::msk_share_t addsub_res;
  logic reg_en;
  logic step;
  logic left;
  logic rotate;
  logic is_bool;
  logic remask;
  logic sub;

  assign rs2 = {i_req.rs2_s1, i_req.rs2_s0.word};

  msk_alu_ctl msk_alu_ctl_inst (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .i_valid     (i_valid),
    .i_op        (i_req.op),
    .i_not_res   (not_res),
    .i_and_res   (and_res),
    .i_ior_res   (ior_res),
    .i_xor_res   (xor_res),
    .i_shf_res   ({shf_s1, shf_s0}),
    .i_gf_res    (gf_res),
    .i_arith_res (mask_res),
    .i_addsub_res(addsub_res),
    .o_reg_en    (reg_en),
    .o_step      (step),
    .o_ready     (o_ready),
    .o_left      (left),
    .o_rotate    (rotate),
    .o_bool      (is_bool),
    .o_remask    (remask),
    .o_sub       (sub),
    .o_rd        (o_rd)
  );

  msk_prng #(.PRNG_SEED(PRNG_SEED)) msk_prng_inst (
    .g_clk   (g_clk),
    .g_resetn(g_resetn),
    .i_step  (step),
    .o_rand  (rand_w)
  );

  msk_logic msk_logic_inst (
    .g_clk   (g_clk),
    .g_resetn(g_resetn),
    .i_en    (reg_en),
    .i_a     (i_req.rs1),
    .i_b     (rs2),
    .i_guard (rand_w),
    .o_not   (not_res),
    .o_and   (and_res),
    .o_ior   (ior_res),
    .o_xor   (xor_res)
  );

  // Same padding on both shares so it cancels in the unmasked value
  msk_shift_share msk_shift_s0_inst (
    .i_share (i_req.rs1.s0),
    .i_shamt (i_req.rs2_s0.shift.shamt),
    .i_pad   (rand_w),
    .i_left  (left),
    .i_rotate(rotate),
    .o_share (shf_s0)
  );

  msk_shift_share msk_shift_s1_inst (
    .i_share (i_req.rs1.s1),
    .i_shamt (i_req.rs2_s0.shift.shamt),
    .i_pad   (rand_w),
    .i_left  (left),
    .i_rotate(rotate),
    .o_share (shf_s1)
  );

  msk_gf_mul msk_gf_mul_inst (
    .i_a    (i_req.rs1),
    .i_b    (rs2),
    .i_guard(rand_w),
    .o_r    (gf_res)
  );

  msk_arith msk_arith_inst (
    .g_clk   (g_clk),
    .g_resetn(g_resetn),
    .i_en    (reg_en),
    .i_bool  (is_bool),
    .i_remask(remask),
    .i_sub   (sub),
    .i_a     (i_req.rs1),
    .i_b     (rs2),
    .i_rand  (rand_w),
    .o_mask  (mask_res),
    .o_addsub(addsub_res)
  );

endmodule

`default_nettype wire

// ==== design/msk_arith.sv ====
// ============================
// Mask, remask and arithmetic add/sub
// Boolean or arithmetic, share 0 registered
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_arith (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_en,
  input  logic                    i_bool,    // Boolean domain, else arithmetic
  input  logic                    i_remask,
  input  logic                    i_sub,
  input  msk_alu_pkg::msk_share_t i_a,
  input  msk_alu_pkg::msk_share_t i_b,
  input  msk_alu_pkg::msk_word_t  i_rand,
  output msk_alu_pkg::msk_share_t o_mask,
  output msk_alu_pkg::msk_share_t o_addsub
);

  msk_alu_pkg::msk_word_t m_d;
  msk_alu_pkg::msk_word_t m_q;
  msk_alu_pkg::msk_word_t rm;  // Old share 1 taken out

  assign m_d = i_bool ? (i_a.s0 ^ i_rand) : (i_a.s0 + i_rand);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      m_q <= '0;
    end else if (i_en) begin
      m_q <= m_d;
    end
  end

  assign rm     = i_bool ? (m_q ^ i_a.s1) : (m_q - i_a.s1);
  assign o_mask = {i_rand, i_remask ? rm : m_q};  // Random word becomes share 1

  // s0 - s1 is linear, so each share is added on its own
  assign o_addsub = i_sub ? {i_a.s1 - i_b.s1, i_a.s0 - i_b.s0}
                          : {i_a.s1 + i_b.s1, i_a.s0 + i_b.s0};

endmodule

`default_nettype wire

// ==== design/msk_gf_mul.sv ====
// ============================
// Masked GF(2^8) multiply
// Byte-wise AES field product, guard refreshed
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_gf_mul (
  input  msk_alu_pkg::msk_share_t i_a,
  input  msk_alu_pkg::msk_share_t i_b,
  input  msk_alu_pkg::msk_word_t  i_guard,
  output msk_alu_pkg::msk_share_t o_r
);

  // Shift-and-add with reduction by x^8 + x^4 + x^3 + x + 1
  function automatic msk_alu_pkg::msk_word_t gf_mul_word(input msk_alu_pkg::msk_word_t a,
                                                         input msk_alu_pkg::msk_word_t b);
    msk_alu_pkg::msk_word_t r;
    logic [7:0]             acc;
    logic [7:0]             x;
    for (int j = 0; j < msk_alu_pkg::XLEN / 8; j++) begin
      acc = 8'h00;
      x   = a[8*j +: 8];
      for (int i = 0; i < 8; i++) begin
        if (b[8*j+i]) begin
          acc = acc ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1B : 8'h00);
      end
      r[8*j +: 8] = acc;
    end
    return r;
  endfunction

  msk_alu_pkg::msk_word_t p00;
  msk_alu_pkg::msk_word_t p11;
  msk_alu_pkg::msk_word_t p01;
  msk_alu_pkg::msk_word_t p10;

  assign p00 = gf_mul_word(i_a.s0, i_b.s0);
  assign p11 = gf_mul_word(i_a.s1, i_b.s1);
  assign p01 = gf_mul_word(i_a.s0, i_b.s1);  // Cross products fold into share 1
  assign p10 = gf_mul_word(i_a.s1, i_b.s0);

  assign o_r = {p11 ^ p01 ^ p10 ^ i_guard, p00 ^ i_guard};

endmodule

`default_nettype wire

// ==== design/msk_logic.sv ====
// ============================
// Masked Boolean logic
// Registered TI AND/OR/XOR, refreshed NOT
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_logic (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_en,
  input  msk_alu_pkg::msk_share_t i_a,
  input  msk_alu_pkg::msk_share_t i_b,
  input  msk_alu_pkg::msk_word_t  i_guard,
  output msk_alu_pkg::msk_share_t o_not,
  output msk_alu_pkg::msk_share_t o_and,
  output msk_alu_pkg::msk_share_t o_ior,
  output msk_alu_pkg::msk_share_t o_xor
);

  localparam int W = msk_alu_pkg::XLEN;

  // Guarded cross products, upper pair sums to share 0
  function automatic logic [4*W-1:0] ti_terms(input msk_alu_pkg::msk_share_t a,
                                              input msk_alu_pkg::msk_share_t b,
                                              input msk_alu_pkg::msk_word_t g);
    ti_terms = {g ^ (a.s0 & b.s0), a.s1 & b.s0, g ^ (a.s0 & b.s1), a.s1 & b.s1};
  endfunction

  msk_alu_pkg::msk_share_t na;  // ~a, share 1 complemented
  msk_alu_pkg::msk_share_t nb;
  msk_alu_pkg::msk_share_t xor_q;
  logic [4*W-1:0]          and_q;
  logic [4*W-1:0]          ior_q;

  assign na = {~i_a.s1, i_a.s0};
  assign nb = {~i_b.s1, i_b.s0};

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      xor_q <= '0;
      and_q <= '0;
      ior_q <= '0;
    end else if (i_en) begin
      xor_q <= i_a ^ i_b;  // Share-wise
      and_q <= ti_terms(i_a, i_b, i_guard);
      ior_q <= ti_terms(na, nb, i_guard);  // a | b = ~(~a & ~b)
    end
  end

  assign o_and = {and_q[2*W-1 -: W] ^ and_q[W-1:0], and_q[4*W-1 -: W] ^ and_q[3*W-1 -: W]};
  assign o_ior = {~(ior_q[2*W-1 -: W] ^ ior_q[W-1:0]),
                  ior_q[4*W-1 -: W] ^ ior_q[3*W-1 -: W]};

  assign o_xor = {xor_q.s1 ^ i_guard, xor_q.s0 ^ i_guard};
  assign o_not = {~i_a.s1 ^ i_guard, i_a.s0 ^ i_guard};

endmodule

`default_nettype wire

// ==== design/msk_prng.sv ====
// ============================
// Mask randomness LFSR
// 32-bit XNOR LFSR, advances per op
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_prng #(
  parameter msk_alu_pkg::msk_word_t PRNG_SEED = 32'h6789_ABCD
) (
  input  logic                   g_clk,
  input  logic                   g_resetn,
  input  logic                   i_step,
  output msk_alu_pkg::msk_word_t o_rand
);

  msk_alu_pkg::msk_word_t lfsr_q;
  logic                   fb;

  assign fb = lfsr_q[31] ~^ lfsr_q[21] ~^ lfsr_q[1] ~^ lfsr_q[0];  // XNOR taps

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr_q <= PRNG_SEED;
    end else if (i_step) begin
      lfsr_q <= {lfsr_q[30:0], fb};
    end
  end

  assign o_rand = lfsr_q;

  // All ones is the lock-up state of an XNOR LFSR
  a_no_lockup: assert property (@(posedge g_clk) disable iff (!g_resetn) lfsr_q != '1)
    else $error("LFSR stuck at all ones");

endmodule

`default_nettype wire

// ==== design/msk_shift_share.sv ====
// ============================
// Share shifter/rotator
// Five-level barrel shift with random padding
// ============================
`timescale 1ns/100ps
`default_nettype none

module msk_shift_share (
  input  logic [msk_alu_pkg::SHAMT_W-1:0] i_shamt,
  input  msk_alu_pkg::msk_word_t          i_share,
  input  msk_alu_pkg::msk_word_t          i_pad,     // Same word for both shares
  input  logic                            i_left,
  input  logic                            i_rotate,  // Rotate right
  output msk_alu_pkg::msk_word_t          o_share
);

  localparam int W = msk_alu_pkg::XLEN;

  msk_alu_pkg::msk_word_t lv [msk_alu_pkg::SHAMT_W+1];

  assign lv[0] = i_share;

  for (genvar k = 0; k < msk_alu_pkg::SHAMT_W; k++) begin : g_level
    localparam int N = 1 << k;

    msk_alu_pkg::msk_word_t shl;
    msk_alu_pkg::msk_word_t shr;

    // Each level takes its padding from its own bit range
    assign shl = {lv[k][W-1-N:0], i_pad[W-N -: N]};
    assign shr = {i_rotate ? lv[k][N-1:0] : i_pad[2*N-2 -: N], lv[k][W-1:N]};

    assign lv[k+1] = !i_shamt[k] ? lv[k] :
                     i_left      ? shl   :
                                   shr;
  end

  assign o_share = lv[msk_alu_pkg::SHAMT_W];

endmodule

`default_nettype wire

// ==== msk_alu_top.f ====
+incdir+test
design/msk_alu_pkg.sv
design/msk_prng.sv
design/msk_logic.sv
design/msk_shift_share.sv
design/msk_gf_mul.sv
design/msk_arith.sv
design/msk_alu_ctl.sv
design/msk_alu_top.sv
test/msk_alu_tb.sv

// ==== test/msk_alu_vectors.svh ====
// ==============================
// Masked ALU test vectors
// Plain operands and expected plain results per op
// ==============================
`ifndef MSK_ALU_VECTORS_SVH
`define MSK_ALU_VECTORS_SVH

// Fields are op, plain a, plain b, expected plain result and domain
typedef struct packed {
  msk_alu_pkg::msk_op_e   op;
  msk_alu_pkg::msk_word_t a;
  msk_alu_pkg::msk_word_t b;
  msk_alu_pkg::msk_word_t exp;
  logic                   arith;  // Shares combine by subtraction
} vec_t;

// A registered op opens the table so its ready follows a rising valid
// Other registered ops sit next to each other and run back to back
task automatic load_vectors();
  add_vec("and",     msk_alu_pkg::B_AND,    32'hDEAD_BEEF, 32'h0F0F_3C3C, 32'h0E0D_3C2C, 1'b0);
  add_vec("not",     msk_alu_pkg::B_NOT,    32'hDEAD_BEEF, 32'h0F0F_3C3C, 32'h2152_4110, 1'b0);
  add_vec("srli",    msk_alu_pkg::B_SRLI,   32'hDEAD_BEEF, 32'h0000_0024, 32'h0DEA_DBEE, 1'b0);
  add_vec("slli",    msk_alu_pkg::B_SLLI,   32'hDEAD_BEEF, 32'h0000_0008, 32'hADBE_EF00, 1'b0);
  add_vec("rori",    msk_alu_pkg::B_RORI,   32'hDEAD_BEEF, 32'h0000_002C, 32'hEEFD_EADB, 1'b0);
  add_vec("srli_31", msk_alu_pkg::B_SRLI,   32'h8000_0001, 32'h0000_001F, 32'h0000_0001, 1'b0);
  add_vec("slli_0",  msk_alu_pkg::B_SLLI,   32'h8000_0001, 32'h0000_0000, 32'h8000_0001, 1'b0);
  add_vec("rori_1",  msk_alu_pkg::B_RORI,   32'h0000_0003, 32'h0000_0001, 32'h8000_0001, 1'b0);
  add_vec("ior",     msk_alu_pkg::B_IOR,    32'hDEAD_BEEF, 32'h0F0F_3C3C, 32'hDFAF_BEFF, 1'b0);
  add_vec("xor",     msk_alu_pkg::B_XOR,    32'hDEAD_BEEF, 32'h0F0F_3C3C, 32'hD1A2_82D3, 1'b0);
  add_vec("bmask",   msk_alu_pkg::B_MASK,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 1'b0);
  add_vec("bremask", msk_alu_pkg::B_REMASK, 32'hCAFE_F00D, 32'h0000_0000, 32'hCAFE_F00D, 1'b0);
  add_vec("amask",   msk_alu_pkg::A_MASK,   32'h89AB_CDEF, 32'h0000_0000, 32'h89AB_CDEF, 1'b1);
  add_vec("aremask", msk_alu_pkg::A_REMASK, 32'h0BAD_F00D, 32'h0000_0000, 32'h0BAD_F00D, 1'b1);
  add_vec("add",     msk_alu_pkg::A_ADD,    32'hFFFF_FFF0, 32'h0000_0020, 32'h0000_0010, 1'b1);
  add_vec("add_2",   msk_alu_pkg::A_ADD,    32'h1234_5678, 32'h1111_1111, 32'h2345_6789, 1'b1);
  add_vec("sub",     msk_alu_pkg::A_SUB,    32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE, 1'b1);
  add_vec("sub_2",   msk_alu_pkg::A_SUB,    32'h89AB_CDEF, 32'h0123_4567, 32'h8888_8888, 1'b1);
  add_vec("gf_fips", msk_alu_pkg::F_MUL,    32'h5757_5701, 32'h8313_0101, 32'hC1FE_5701, 1'b0);
  add_vec("gf_mix",  msk_alu_pkg::F_MUL,    32'hA53C_FF80, 32'h1BC6_0280,
          gf_mul_bytes(32'hA53C_FF80, 32'h1BC6_0280), 1'b0);
  add_vec("and_2",   msk_alu_pkg::B_AND,    32'hFFFF_0000, 32'h0F0F_0F0F, 32'h0F0F_0000, 1'b0);
  add_vec("xor_2",   msk_alu_pkg::B_XOR,    32'h0000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
endtask

`endif

// ==== test/msk_alu_tb.sv ====
// ==============================
// Masked ALU testbench
// Shares operands, runs the vector table back to back
// and checks unmasked results and ready latency
// ==============================
`timescale 1ns/100ps
`default_nettype none

module msk_alu_tb;

  logic                    g_clk;
  logic                    g_resetn;
  logic                    i_valid;
  msk_alu_pkg::msk_req_t   i_req;
  logic                    o_ready;
  msk_alu_pkg::msk_share_t o_rd;

  `include "msk_alu_vectors.svh"

  vec_t   vecs[$];
  string  names[$];
  integer seed;
  int     cycles;
  int     cycle_limit;

  msk_alu_top #(.PRNG_SEED(32'h6789_ABCD)) msk_alu_top_inst (
    .g_clk   (g_clk),
    .g_resetn(g_resetn),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_ready (o_ready),
    .o_rd    (o_rd)
  );

  initial g_clk = 1'b0;
  always #2 g_clk = ~g_clk;  // 4 ns period

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic add_vec(input string name, input msk_alu_pkg::msk_op_e op,
                         input msk_alu_pkg::msk_word_t a, input msk_alu_pkg::msk_word_t b,
                         input msk_alu_pkg::msk_word_t exp, input logic arith);
    names.push_back(name);
    vecs.push_back({op, a, b, exp, arith});
  endtask

  // Horner form over the bits of a, reduced by 11B hex
  function automatic msk_alu_pkg::msk_word_t gf_mul_bytes(input msk_alu_pkg::msk_word_t a,
                                                          input msk_alu_pkg::msk_word_t b);
    msk_alu_pkg::msk_word_t r;
    logic [7:0]             p;
    for (int j = 0; j < 4; j++) begin
      p = 8'h00;
      for (int i = 7; i >= 0; i--) begin
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1B : 8'h00);  // Times x
        if (a[8*j+i]) begin
          p = p ^ b[8*j +: 8];
        end
      end
      r[8*j +: 8] = p;
    end
    return r;
  endfunction

  // Logic and mask ops need one extra cycle
  function automatic int expected_latency(input msk_alu_pkg::msk_op_e op);
    case (op)
      msk_alu_pkg::B_AND, msk_alu_pkg::B_IOR, msk_alu_pkg::B_XOR,
      msk_alu_pkg::B_MASK, msk_alu_pkg::B_REMASK,
      msk_alu_pkg::A_MASK, msk_alu_pkg::A_REMASK: return 1;
      default: return 0;
    endcase
  endfunction

  task automatic check_bool(input string name, input msk_alu_pkg::msk_word_t exp,
                            input msk_alu_pkg::msk_share_t act);
    msk_alu_pkg::msk_word_t val;
    val = act.s0 ^ act.s1;
    if (val !== exp) begin
      stop_on_error($sformatf("Error: %s expected %08h, actual %08h", name, exp, val));
    end
  endtask

  task automatic check_arith(input string name, input msk_alu_pkg::msk_word_t exp,
                             input msk_alu_pkg::msk_share_t act);
    msk_alu_pkg::msk_word_t val;
    val = act.s0 - act.s1;
    if (val !== exp) begin
      stop_on_error($sformatf("Error: %s expected %08h, actual %08h", name, exp, val));
    end
  endtask

  task automatic check_ready_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_on_error($sformatf("Error: %s ready latency expected %0d, actual %0d",
                              name, exp, act));
    end
  endtask

  task automatic build_req(input vec_t v, output msk_alu_pkg::msk_req_t req);
    msk_alu_pkg::msk_word_t ma;
    msk_alu_pkg::msk_word_t mb;
    ma = $random(seed);
    mb = $random(seed);
    req.op          = v.op;
    req.rs1         = v.arith ? {ma, v.a + ma} : {ma, v.a ^ ma};
    req.rs2_s0.word = v.arith ? v.b + mb : v.b ^ mb;
    req.rs2_s1      = mb;
    case (v.op)
      msk_alu_pkg::B_SRLI, msk_alu_pkg::B_SLLI, msk_alu_pkg::B_RORI: begin
        req.rs2_s0.word = v.b;  // Plain shift amount
        req.rs2_s1      = '0;
      end
      msk_alu_pkg::B_MASK, msk_alu_pkg::A_MASK: req.rs1.s0 = v.a;
      default: req.rs2_s1 = mb;
    endcase
  endtask

  // Drives one entry and holds it until ready, sampled at the falling edge
  task automatic run_vec(input int idx);
    msk_alu_pkg::msk_req_t   req;
    msk_alu_pkg::msk_share_t rd;
    int                      waited;
    build_req(vecs[idx], req);
    i_req   = req;
    i_valid = 1'b1;
    waited  = 0;
    @(negedge g_clk);
    while (!o_ready) begin
      @(negedge g_clk);
      waited++;
    end
    rd = o_rd;
    check_ready_latency(names[idx], expected_latency(vecs[idx].op), waited);
    if (vecs[idx].arith) begin
      check_arith(names[idx], vecs[idx].exp, rd);
    end else begin
      check_bool(names[idx], vecs[idx].exp, rd);
    end
    @(posedge g_clk);
    #0.5;
  endtask

  always @(posedge g_clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      stop_on_error("Timeout: the ALU never raised ready");
    end
  end

  initial begin
    seed     = 36014;
    cycles   = 0;
    g_resetn = 1'b0;
    i_valid  = 1'b0;
    i_req    = '0;
    load_vectors();
    cycle_limit = 8 + 4 * vecs.size() + 20;
    repeat (8) @(posedge g_clk);
    #0.5;
    g_resetn = 1'b1;
    repeat (2) begin
      @(negedge g_clk);
      if (o_ready !== 1'b0) begin
        stop_on_error("Ready went high after reset with no request pending");
      end
    end
    @(posedge g_clk);
    #0.5;
    foreach (vecs[i]) begin
      run_vec(i);  // Valid stays high between entries
    end
    i_valid = 1'b0;
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
